// File: design/edge_walker.sv
`timescale 1ns/1ps
`default_nettype none

module edge_walker (
  input  wire                      clk_in,
  input  wire                      reset,
  input  wire  rast_pkg::hcount_t  h_min, h_max,
  input  wire  rast_pkg::vcount_t  v_min, v_max,
  input  wire                      box_empty,
  input  wire  rast_pkg::edge_t    a0, b0,
  input  wire  rast_pkg::edge_t    a1, b1,
  input  wire  rast_pkg::edge_t    a2, b2,
  input  wire  rast_pkg::edge_t    e0, e1, e2,
  input  wire  rast_pkg::depth_t   z_min,
  input  wire                      valid_in,
  output logic                     ready_out,
  output rast_pkg::hcount_t        hcount_out,
  output rast_pkg::vcount_t        vcount_out,
  output rast_pkg::depth_t         z_out,
  output logic                     valid_out,
  output logic                     tri_done_out,
  input  wire                      ready_in
);

  rast_pkg::walk_state_t state;

  // box of the triangle being walked
  rast_pkg::hcount_t h_start;
  rast_pkg::hcount_t h_end;
  rast_pkg::vcount_t v_end;

  // current pixel
  rast_pkg::hcount_t h;
  rast_pkg::vcount_t v;
  rast_pkg::depth_t z;

  // step coefficients held for the walk
  rast_pkg::edge_t step_a0, step_a1, step_a2;
  rast_pkg::edge_t step_b0, step_b1, step_b2;

  // edge values at the row start and at the current pixel
  rast_pkg::edge_t row0, row1, row2;
  rast_pkg::edge_t cur0, cur1, cur2;

  logic covered;
  logic advance;
  logic row_end;
  logic last;
  logic load;

  // inside for either winding
  assign covered = ((cur0 >= 0) && (cur1 >= 0) && (cur2 >= 0)) ||
                   ((cur0 <= 0) && (cur1 <= 0) && (cur2 <= 0));

  assign valid_out = (state == rast_pkg::WALK_SCAN) && covered;
  // step unless a covered pixel is waiting on the sink
  assign advance = (state == rast_pkg::WALK_SCAN) && (!valid_out || ready_in);
  assign row_end = (h == h_end);
  assign last = row_end && (v == v_end);

  // a new setup may load while idle or in the done cycle
  assign ready_out = (state != rast_pkg::WALK_SCAN);
  assign load = ready_out && valid_in;
  assign tri_done_out = (state == rast_pkg::WALK_DONE);

  assign hcount_out = h;
  assign vcount_out = v;
  assign z_out = z;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state <= rast_pkg::WALK_IDLE;
    end else begin
      case (state)
        rast_pkg::WALK_IDLE, rast_pkg::WALK_DONE: begin
          if (load) begin
            // an empty box skips straight to the done pulse
            state <= box_empty ? rast_pkg::WALK_DONE : rast_pkg::WALK_SCAN;
          end else begin
            state <= rast_pkg::WALK_IDLE;
          end
        end
        rast_pkg::WALK_SCAN: begin
          if (advance && last) begin
            state <= rast_pkg::WALK_DONE;
          end
        end
        default: begin
          state <= rast_pkg::WALK_IDLE;
        end
      endcase
    end
  end

  // walk datapath adds only
  always_ff @(posedge clk_in) begin
    if (load) begin
      h_start <= h_min;
      h_end <= h_max;
      v_end <= v_max;
      h <= h_min;
      v <= v_min;
      z <= z_min;
      step_a0 <= a0;
      step_a1 <= a1;
      step_a2 <= a2;
      step_b0 <= b0;
      step_b1 <= b1;
      step_b2 <= b2;
      row0 <= e0;
      row1 <= e1;
      row2 <= e2;
      cur0 <= e0;
      cur1 <= e1;
      cur2 <= e2;
    end else if (advance) begin
      if (row_end) begin
        // back to the left edge and one row down
        h <= h_start;
        v <= v + 1'b1;
        row0 <= row0 + step_b0;
        row1 <= row1 + step_b1;
        row2 <= row2 + step_b2;
        cur0 <= row0 + step_b0;
        cur1 <= row1 + step_b1;
        cur2 <= row2 + step_b2;
      end else begin
        h <= h + 1'b1;
        cur0 <= cur0 + step_a0;
        cur1 <= cur1 + step_a1;
        cur2 <= cur2 + step_a2;
      end
    end
  end

  // emitted pixels stay within the clamped box
  a_pixel_in_box: assert property (@(posedge clk_in) disable iff (reset)
    valid_out |-> (hcount_out >= h_start) && (hcount_out <= h_end) &&
                  (hcount_out < rast_pkg::FB_HRES) && (vcount_out <= v_end));

  // a stalled pixel keeps its position and depth until taken
  a_pixel_held: assert property (@(posedge clk_in) disable iff (reset)
    (valid_out && !ready_in) |=>
      (valid_out && $stable({hcount_out, vcount_out, z_out})));

endmodule

`default_nettype wire

// File: design/rast_pkg.sv
`default_nettype none

package rast_pkg;

  // framebuffer size in pixels
  localparam int FB_HRES = 320;
  localparam int FB_VRES = 180;

  // fraction bits of x, y, z and the scale factors
  localparam int FRAC = 14;

  // view coordinate, 3 integer bits and 14 fraction bits
  typedef logic signed [16:0] coord_t;

  // depth value, 14 fraction bits
  typedef logic signed [28:0] depth_t;

  // integer pixel coordinate before clamping
  // wide enough for roughly +-4 view units
  typedef logic signed [10:0] scr_t;

  // clamped pixel column and row
  typedef logic [8:0] hcount_t;
  typedef logic [7:0] vcount_t;

  // edge function value and its per-step increments
  typedef logic signed [23:0] edge_t;

  // pixels per view unit, 14 fraction bits
  typedef logic signed [22:0] scale_t;

  // 320 / 3 and 180 / 3 in fixed point
  localparam scale_t HRES_BY_VW = 23'sd1747627;
  localparam scale_t VRES_BY_VH = 23'sd983040;

  // half the 3 by 3 view window, 1.5 in coord_t
  localparam coord_t HALF_VW = coord_t'(3 << (FRAC - 1));
  localparam coord_t HALF_VH = coord_t'(3 << (FRAC - 1));

  // scan FSM of the edge walker
  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_SCAN,
    WALK_DONE
  } walk_state_t;

endpackage

`default_nettype wire

// File: design/rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer (
  input  wire                      clk_in,
  input  wire                      reset,
  input  wire  rast_pkg::coord_t   x0, y0,
  input  wire  rast_pkg::depth_t   z0,
  input  wire  rast_pkg::coord_t   x1, y1,
  input  wire  rast_pkg::depth_t   z1,
  input  wire  rast_pkg::coord_t   x2, y2,
  input  wire  rast_pkg::depth_t   z2,
  input  wire                      valid_in,
  output logic                     ready_out,
  output rast_pkg::hcount_t        hcount_out,
  output rast_pkg::vcount_t        vcount_out,
  output rast_pkg::depth_t         z_out,
  output logic                     valid_out,
  input  wire                      ready_in,
  output logic                     tri_done_out
);

  // view_to_pixel to triangle_setup
  rast_pkg::scr_t px0, py0, px1, py1, px2, py2;
  rast_pkg::depth_t pz0, pz1, pz2;
  logic pix_valid;
  logic pix_ready;

  // triangle_setup to edge_walker
  rast_pkg::hcount_t h_min, h_max;
  rast_pkg::vcount_t v_min, v_max;
  logic box_empty;
  rast_pkg::edge_t a0, b0, a1, b1, a2, b2;
  rast_pkg::edge_t e0, e1, e2;
  rast_pkg::depth_t z_min;
  logic set_valid;
  logic set_ready;

  view_to_pixel u_view (
    .clk_in(clk_in),
    .reset(reset),
    .x0(x0), .y0(y0), .x1(x1), .y1(y1), .x2(x2), .y2(y2),
    .z0(z0), .z1(z1), .z2(z2),
    .valid_in(valid_in),
    .ready_out(ready_out),
    .px0(px0), .py0(py0), .px1(px1), .py1(py1), .px2(px2), .py2(py2),
    .pz0(pz0), .pz1(pz1), .pz2(pz2),
    .valid_out(pix_valid),
    .ready_in(pix_ready)
  );

  triangle_setup u_setup (
    .clk_in(clk_in),
    .reset(reset),
    .px0(px0), .py0(py0), .px1(px1), .py1(py1), .px2(px2), .py2(py2),
    .pz0(pz0), .pz1(pz1), .pz2(pz2),
    .valid_in(pix_valid),
    .ready_out(pix_ready),
    .h_min(h_min), .h_max(h_max), .v_min(v_min), .v_max(v_max),
    .box_empty(box_empty),
    .a0(a0), .b0(b0), .a1(a1), .b1(b1), .a2(a2), .b2(b2),
    .e0(e0), .e1(e1), .e2(e2),
    .z_min(z_min),
    .valid_out(set_valid),
    .ready_in(set_ready)
  );

  // variable-latency scan, sets the pace of the whole chain
  edge_walker u_walk (
    .clk_in(clk_in),
    .reset(reset),
    .h_min(h_min), .h_max(h_max), .v_min(v_min), .v_max(v_max),
    .box_empty(box_empty),
    .a0(a0), .b0(b0), .a1(a1), .b1(b1), .a2(a2), .b2(b2),
    .e0(e0), .e1(e1), .e2(e2),
    .z_min(z_min),
    .valid_in(set_valid),
    .ready_out(set_ready),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out),
    .z_out(z_out),
    .valid_out(valid_out),
    .tri_done_out(tri_done_out),
    .ready_in(ready_in)
  );

endmodule

`default_nettype wire

// File: design/triangle_setup.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_setup (
  input  wire                      clk_in,
  input  wire                      reset,
  input  wire  rast_pkg::scr_t     px0, py0,
  input  wire  rast_pkg::scr_t     px1, py1,
  input  wire  rast_pkg::scr_t     px2, py2,
  input  wire  rast_pkg::depth_t   pz0, pz1, pz2,
  input  wire                      valid_in,
  output logic                     ready_out,
  output rast_pkg::hcount_t        h_min, h_max,
  output rast_pkg::vcount_t        v_min, v_max,
  output logic                     box_empty,
  output rast_pkg::edge_t          a0, b0,
  output rast_pkg::edge_t          a1, b1,
  output rast_pkg::edge_t          a2, b2,
  output rast_pkg::edge_t          e0, e1, e2,
  output rast_pkg::depth_t         z_min,
  output logic                     valid_out,
  input  wire                      ready_in
);

  function automatic rast_pkg::scr_t min3(input rast_pkg::scr_t p, q, r);
    rast_pkg::scr_t m;
    m = (p < q) ? p : q;
    return (r < m) ? r : m;
  endfunction

  function automatic rast_pkg::scr_t max3(input rast_pkg::scr_t p, q, r);
    rast_pkg::scr_t m;
    m = (p > q) ? p : q;
    return (r > m) ? r : m;
  endfunction

  // raw box from the vertex extremes
  rast_pkg::scr_t x_lo, x_hi, y_lo, y_hi;
  // box clamped to the framebuffer
  rast_pkg::scr_t h_lo, h_hi, v_lo, v_hi;
  logic off_screen;
  // vertices and box corner sign-extended to edge width
  rast_pkg::edge_t sx0, sy0, sx1, sy1, sx2, sy2;
  rast_pkg::edge_t sh, sv;
  rast_pkg::edge_t ca0, cb0, ca1, cb1, ca2, cb2;
  rast_pkg::edge_t ce0, ce1, ce2;
  rast_pkg::edge_t area;
  rast_pkg::depth_t zm;

  assign x_lo = min3(px0, px1, px2);
  assign x_hi = max3(px0, px1, px2);
  assign y_lo = min3(py0, py1, py2);
  assign y_hi = max3(py0, py1, py2);

  // nothing of the box lands on the screen
  assign off_screen = (x_hi < 0) || (x_lo > rast_pkg::FB_HRES - 1) ||
                      (y_hi < 0) || (y_lo > rast_pkg::FB_VRES - 1);

  assign h_lo = (x_lo < 0) ? '0 : x_lo;
  assign v_lo = (y_lo < 0) ? '0 : y_lo;
  assign h_hi = (x_hi > rast_pkg::FB_HRES - 1) ? rast_pkg::scr_t'(rast_pkg::FB_HRES - 1) : x_hi;
  assign v_hi = (y_hi > rast_pkg::FB_VRES - 1) ? rast_pkg::scr_t'(rast_pkg::FB_VRES - 1) : y_hi;

  assign sx0 = px0;
  assign sy0 = py0;
  assign sx1 = px1;
  assign sy1 = py1;
  assign sx2 = px2;
  assign sy2 = py2;
  assign sh = h_lo;
  assign sv = v_lo;

  // edge i runs from vertex i to vertex i+1
  // E(x,y) = (x - xi) * a + (y - yi) * b
  // a is the step along a row, b the step down a column
  assign ca0 = sy1 - sy0;
  assign cb0 = sx0 - sx1;
  assign ca1 = sy2 - sy1;
  assign cb1 = sx1 - sx2;
  assign ca2 = sy0 - sy2;
  assign cb2 = sx2 - sx0;

  // edge values at the top-left box corner
  assign ce0 = (sh - sx0) * ca0 + (sv - sy0) * cb0;
  assign ce1 = (sh - sx1) * ca1 + (sv - sy1) * cb1;
  assign ce2 = (sh - sx2) * ca2 + (sv - sy2) * cb2;

  // twice the signed area, zero for degenerate triangles
  assign area = (sx2 - sx0) * ca0 + (sy2 - sy0) * cb0;

  // flat depth, nearest vertex
  always_comb begin
    zm = pz0;
    if (pz1 < zm) zm = pz1;
    if (pz2 < zm) zm = pz2;
  end

  assign ready_out = !valid_out || ready_in;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk_in) begin
    if (ready_out && valid_in) begin
      h_min <= rast_pkg::hcount_t'(h_lo);
      h_max <= rast_pkg::hcount_t'(h_hi);
      v_min <= rast_pkg::vcount_t'(v_lo);
      v_max <= rast_pkg::vcount_t'(v_hi);
      box_empty <= off_screen || (area == 0);
      a0 <= ca0;
      b0 <= cb0;
      a1 <= ca1;
      b1 <= cb1;
      a2 <= ca2;
      b2 <= cb2;
      e0 <= ce0;
      e1 <= ce1;
      e2 <= ce2;
      z_min <= zm;
    end
  end

endmodule

`default_nettype wire

// File: design/view_to_pixel.sv
`timescale 1ns/1ps
`default_nettype none

module view_to_pixel (
  input  wire                      clk_in,
  input  wire                      reset,
  input  wire  rast_pkg::coord_t   x0, y0,
  input  wire  rast_pkg::coord_t   x1, y1,
  input  wire  rast_pkg::coord_t   x2, y2,
  input  wire  rast_pkg::depth_t   z0, z1, z2,
  input  wire                      valid_in,
  output logic                     ready_out,
  output rast_pkg::scr_t           px0, py0,
  output rast_pkg::scr_t           px1, py1,
  output rast_pkg::scr_t           px2, py2,
  output rast_pkg::depth_t         pz0, pz1, pz2,
  output logic                     valid_out,
  input  wire                      ready_in
);

  // shift to a 0-based window, scale, drop the 28 fraction bits
  // arithmetic shift of the signed product floors toward -inf
  function automatic rast_pkg::scr_t to_pixel(input rast_pkg::coord_t c,
                                              input rast_pkg::coord_t half,
                                              input rast_pkg::scale_t scale);
    logic signed [17:0] shifted;
    logic signed [40:0] prod;
    shifted = c + half;
    prod = shifted * scale;
    return rast_pkg::scr_t'(prod >>> (2 * rast_pkg::FRAC));
  endfunction

  // one-entry stage, loads when empty or being drained
  assign ready_out = !valid_out || ready_in;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  // payload, only written on a transfer
  always_ff @(posedge clk_in) begin
    if (ready_out && valid_in) begin
      px0 <= to_pixel(x0, rast_pkg::HALF_VW, rast_pkg::HRES_BY_VW);
      px1 <= to_pixel(x1, rast_pkg::HALF_VW, rast_pkg::HRES_BY_VW);
      px2 <= to_pixel(x2, rast_pkg::HALF_VW, rast_pkg::HRES_BY_VW);
      py0 <= to_pixel(y0, rast_pkg::HALF_VH, rast_pkg::VRES_BY_VH);
      py1 <= to_pixel(y1, rast_pkg::HALF_VH, rast_pkg::VRES_BY_VH);
      py2 <= to_pixel(y2, rast_pkg::HALF_VH, rast_pkg::VRES_BY_VH);
      // depth passes through untouched
      pz0 <= z0;
      pz1 <= z1;
      pz2 <= z2;
    end
  end

  // held vertices must not move while downstream stalls
  a_hold_stable: assert property (@(posedge clk_in) disable iff (reset)
    (valid_out && !ready_in) |=>
      (valid_out && $stable({px0, py0, px1, py1, px2, py2, pz0, pz1, pz2})));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module rasterizer_tb -o rasterizer_sim

output=$(./obj_dir/rasterizer_sim)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// File: src.f
design/rast_pkg.sv
design/view_to_pixel.sv
design/triangle_setup.sv
design/edge_walker.sv
design/rasterizer.sv
test/rasterizer_checker.sv
test/rasterizer_tb.sv

// File: test/rasterizer_cases.txt
# name x0 y0 z0 x1 y1 z1 x2 y2 z2 count hsum vsum zmin
# x y raw view units with 14 fraction bits, z raw depth, all decimal
tri_ccw -23040 -19114 16384 -21504 -19114 8192 -23040 -16384 20000 66 880 1540 8192
tri_cw -9216 -10922 -5000 -9216 -5461 3000 -6144 -10922 100 231 24640 13090 -5000
tri_flip 6144 2731 40000 6144 0 50000 4608 2731 45000 66 12980 6380 40000
part_left -26111 -21845 7 -23040 -21845 8 -26111 -16384 9 66 220 880 7
part_corner 21504 21846 100000 24576 21846 -200000 21504 27307 0 164 50500 28540 -200000
off_left -30719 -21845 1 -27647 -21845 2 -30719 -16384 3 0 0 0 1
line -23040 -21845 5 -21504 -19114 6 -19968 -16384 7 0 0 0 5
repeat -16896 -10922 9 -16896 -10922 8 -15360 -5461 7 0 0 0 7
tri_ccw_again -23040 -19114 16384 -21504 -19114 8192 -23040 -16384 20000 66 880 1540 8192
tri_cw_again -9216 -10922 -5000 -9216 -5461 3000 -6144 -10922 100 231 24640 13090 -5000

// File: test/rasterizer_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer_checker (
  input wire                     clk_in,
  input wire                     reset,
  input wire                     valid_in,
  input wire                     ready_out,
  input wire rast_pkg::hcount_t  hcount_out,
  input wire rast_pkg::vcount_t  vcount_out,
  input wire rast_pkg::depth_t   z_out,
  input wire                     valid_out,
  input wire                     ready_in,
  input wire                     tri_done_out
);

  // expected results, one entry per triangle in flight
  string exp_name[$];
  int exp_count[$];
  int exp_hsum[$];
  int exp_vsum[$];
  int exp_z[$];

  // running totals
  int n_done = 0;
  int n_pass = 0;
  int n_fail = 0;
  int n_err = 0;

  // per-triangle accumulators
  int count = 0;
  int hsum = 0;
  int vsum = 0;
  int last_key = -1;
  int key;
  bit tri_bad = 0;
  bit z_bad = 0;

  // first input transfer seen
  bit started = 0;

  // pixel stalled at the previous edge
  bit held = 0;
  rast_pkg::hcount_t held_h;
  rast_pkg::vcount_t held_v;
  rast_pkg::depth_t held_z;

  task automatic expect_case(input string name, input int cnt, input int hs,
                             input int vs, input int z);
    exp_name.push_back(name);
    exp_count.push_back(cnt);
    exp_hsum.push_back(hs);
    exp_vsum.push_back(vs);
    exp_z.push_back(z);
  endtask

  always @(posedge clk_in) begin
    if (!reset) begin
      // idle outputs until the first triangle goes in
      if (!started) begin
        if (valid_out || tri_done_out || !ready_out) begin
          $display("outputs not idle after reset before any stimulus");
          n_err++;
        end
        if (valid_in && ready_out) begin
          started = 1;
        end
      end

      // a stalled pixel must stay put
      if (held) begin
        if (!valid_out || hcount_out != held_h || vcount_out != held_v ||
            z_out != held_z) begin
          $display("held pixel changed before it was accepted");
          tri_bad = 1;
        end
      end
      held = valid_out && !ready_in;
      held_h = hcount_out;
      held_v = vcount_out;
      held_z = z_out;

      // accepted pixel
      if (valid_out && ready_in) begin
        if (exp_name.size() == 0) begin
          $display("pixel accepted with no triangle outstanding");
          n_err++;
        end else begin
          if (hcount_out >= 320 || vcount_out >= 180) begin
            $display("pixel %0d,%0d outside the framebuffer", hcount_out, vcount_out);
            tri_bad = 1;
          end
          // row-major order check
          key = int'(vcount_out) * 512 + int'(hcount_out);
          if (key <= last_key) begin
            $display("pixel %0d,%0d out of row-major order", hcount_out, vcount_out);
            tri_bad = 1;
          end
          last_key = key;
          if (!z_bad && int'(z_out) != exp_z[0]) begin
            $display("Fail %s expected z %0d actual z %0d", exp_name[0], exp_z[0],
                     int'(z_out));
            z_bad = 1;
          end
          count++;
          hsum += int'(hcount_out);
          vsum += int'(vcount_out);
        end
      end

      // end of triangle
      if (tri_done_out) begin
        if (exp_name.size() == 0) begin
          $display("done pulse with no triangle outstanding");
          n_err++;
        end else begin
          if (count != exp_count[0] || hsum != exp_hsum[0] || vsum != exp_vsum[0]) begin
            $display("Fail %s expected count %0d hsum %0d vsum %0d actual count %0d hsum %0d vsum %0d",
                     exp_name[0], exp_count[0], exp_hsum[0], exp_vsum[0],
                     count, hsum, vsum);
            n_fail++;
          end else if (tri_bad || z_bad) begin
            $display("Fail %s after the errors above", exp_name[0]);
            n_fail++;
          end else begin
            $display("Pass %s", exp_name[0]);
            n_pass++;
          end
          void'(exp_name.pop_front());
          void'(exp_count.pop_front());
          void'(exp_hsum.pop_front());
          void'(exp_vsum.pop_front());
          void'(exp_z.pop_front());
        end
        n_done++;
        count = 0;
        hsum = 0;
        vsum = 0;
        last_key = -1;
        tri_bad = 0;
        z_bad = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/rasterizer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer_tb;

  logic clk_in = 1'b0;
  logic reset;
  rast_pkg::coord_t x0, y0, x1, y1, x2, y2;
  rast_pkg::depth_t z0, z1, z2;
  logic valid_in;
  logic ready_out;
  rast_pkg::hcount_t hcount_out;
  rast_pkg::vcount_t vcount_out;
  rast_pkg::depth_t z_out;
  logic valid_out;
  logic ready_in;
  logic tri_done_out;

  // vertex values of the current case, x y z per vertex
  int tri_v[9];
  int n_cases = 0;
  bit aborted = 0;

  // 8 ns period
  always #4 clk_in = ~clk_in;

  rasterizer u_dut (
    .clk_in(clk_in),
    .reset(reset),
    .x0(x0), .y0(y0), .z0(z0),
    .x1(x1), .y1(y1), .z1(z1),
    .x2(x2), .y2(y2), .z2(z2),
    .valid_in(valid_in),
    .ready_out(ready_out),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out),
    .z_out(z_out),
    .valid_out(valid_out),
    .ready_in(ready_in),
    .tri_done_out(tri_done_out)
  );

  rasterizer_checker u_check (
    .clk_in(clk_in),
    .reset(reset),
    .valid_in(valid_in),
    .ready_out(ready_out),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out),
    .z_out(z_out),
    .valid_out(valid_out),
    .ready_in(ready_in),
    .tri_done_out(tri_done_out)
  );

  // sink stalls on about a third of cycles
  always @(negedge clk_in) begin
    if (!reset) begin
      ready_in <= ($urandom % 3) != 0;
    end
  end

  // present one triangle, hold it until taken
  task automatic send_triangle();
    int waited;
    waited = 0;
    repeat ($urandom % 4) @(negedge clk_in);
    x0 = rast_pkg::coord_t'(tri_v[0]);
    y0 = rast_pkg::coord_t'(tri_v[1]);
    z0 = rast_pkg::depth_t'(tri_v[2]);
    x1 = rast_pkg::coord_t'(tri_v[3]);
    y1 = rast_pkg::coord_t'(tri_v[4]);
    z1 = rast_pkg::depth_t'(tri_v[5]);
    x2 = rast_pkg::coord_t'(tri_v[6]);
    y2 = rast_pkg::coord_t'(tri_v[7]);
    z2 = rast_pkg::depth_t'(tri_v[8]);
    valid_in = 1'b1;
    // ready_out only moves on rising edges
    while (!ready_out && waited < 5000) begin
      @(negedge clk_in);
      waited++;
    end
    if (!ready_out) begin
      $display("timeout waiting for ready_out to accept a triangle");
      aborted = 1;
    end
    @(negedge clk_in);
    valid_in = 1'b0;
  endtask

  initial begin
    int fd;
    int n_fields;
    int waited;
    int v[13];
    string line;
    string name;
    void'($urandom(32'hcc2a));
    reset = 1'b1;
    valid_in = 1'b0;
    ready_in = 1'b1;
    x0 = '0;
    y0 = '0;
    z0 = '0;
    x1 = '0;
    y1 = '0;
    z1 = '0;
    x2 = '0;
    y2 = '0;
    z2 = '0;
    repeat (16) @(posedge clk_in);
    @(negedge clk_in);
    reset = 1'b0;
    // idle window for the post-reset output check
    repeat (4) @(negedge clk_in);

    fd = $fopen("test/rasterizer_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      aborted = 1;
    end
    while (!aborted && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;
      n_fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                         v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                         v[9], v[10], v[11], v[12]);
      if (n_fields != 14) begin
        $display("malformed line in the case file");
        aborted = 1;
        break;
      end
      for (int i = 0; i < 9; i++) begin
        tri_v[i] = v[i];
      end
      u_check.expect_case(name, v[9], v[10], v[11], v[12]);
      n_cases++;
      send_triangle();
    end
    if (fd != 0) $fclose(fd);

    // drain remaining done pulses
    waited = 0;
    while (!aborted && u_check.n_done < n_cases && waited < 50000) begin
      @(negedge clk_in);
      waited++;
    end
    if (!aborted && u_check.n_done < n_cases) begin
      $display("timeout waiting for done pulses of all triangles");
      aborted = 1;
    end

    $display("%0d tests passed, %0d tests failed, %0d other errors",
             u_check.n_pass, u_check.n_fail, u_check.n_err);
    if (aborted || u_check.n_fail != 0 || u_check.n_err != 0 ||
        u_check.n_done != n_cases || n_cases == 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

`default_nettype wire
